// ==== verilog.f ====
mmu_pkg.sv
pte_perm_check.sv
sv32_tlb.sv
sv32_ptw.sv
sv32_mmu.sv
tb_page_table_mem.sv
tb_sv32_mmu.sv

// ==== Makefile ====
# Verilator flow for the Sv32 MMU testbench

VERILATOR ?= verilator
TOP       ?= tb_sv32_mmu
FLIST     ?= verilog.f
VFLAGS    ?= -j 0
OBJ_DIR   ?= obj_dir

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# Fails unless the pass message appears in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_sv32_mmu.sv ====
`timescale 1ns/1ps

module tb_sv32_mmu import mmu_pkg::*; ();

  localparam int TLB_N       = 4;
  localparam int N_RAND      = 12;            // Pages in the random permission test
  localparam int N_REQ       = 4 + 2 + 2 * N_RAND + 4 + 6 + 6;
  localparam int CYCLE_LIMIT = 60 * N_REQ + 200;
  localparam logic [PPN_W-1:0] ROOT_PPN = 22'h100;

  logic               clk = 1'b0;
  logic               reset_n;
  logic               req_valid;
  logic [VADDR_W-1:0] req_vaddr;
  access_e            req_access;
  logic               req_done;
  logic [PADDR_W-1:0] req_paddr;
  logic               req_page_fault;
  logic [VADDR_W-1:0] satp;
  priv_mode_e         priv_mode;
  logic               mstatus_sum;
  logic               mstatus_mxr;
  logic               tlb_flush_all;
  logic               tlb_flush_vaddr;
  logic [VADDR_W-1:0] tlb_flush_addr;
  logic               mem_req_valid;
  logic [PADDR_W-1:0] mem_req_addr;
  logic               mem_req_ready;
  logic               mem_resp_valid;
  logic [PTE_W-1:0]   mem_resp_data;

  // Reference page tables and TLB model
  logic [PTE_W-1:0]       pt [logic [PADDR_W-1:0]];
  logic                   m_valid [TLB_N];
  logic [VPN_W-1:0]       m_vpn   [TLB_N];
  logic [PPN_W-1:0]       m_ppn   [TLB_N];
  logic [PTE_FLAGS_W-1:0] m_flags [TLB_N];
  int                     m_victim;

  // Expected results in request order
  logic [PADDR_W-1:0] exp_paddr_q [$];
  logic               exp_fault_q [$];
  int                 exp_reads_q [$];
  int                 start_reads_q [$];

  integer seed = 61;
  int     err_value;
  int     err_other;
  int     cycle_cnt;

  sv32_mmu #(.TLB_ENTRIES(TLB_N)) sv32_mmu_i (.*);

  tb_page_table_mem mem_i (.*);

  always #2 clk = ~clk;

  // ==========================================================
  // Reference model
  // ==========================================================

  function automatic logic perm_ok(input logic [PTE_FLAGS_W-1:0] f, input access_e acc,
                                   input priv_mode_e pm, input logic sum, input logic mxr);
    if (!f[PTE_V] || !(f[PTE_R] || f[PTE_X])) return 1'b0;  // Invalid or pointer
    if (f[PTE_W_BIT] && !f[PTE_R]) return 1'b0;
    if (pm == PRIV_U && !f[PTE_U]) return 1'b0;
    if (pm == PRIV_S && f[PTE_U] && (!sum || acc == ACC_FETCH)) return 1'b0;
    if (acc == ACC_FETCH) return f[PTE_X];
    if (acc == ACC_STORE) return f[PTE_W_BIT];
    return f[PTE_R] || (f[PTE_X] && mxr);
  endfunction

  function automatic logic [PTE_W-1:0] pt_read(input logic [PADDR_W-1:0] a);
    return pt.exists(a) ? pt[a] : '0;
  endfunction

  // Expected result and the TLB fill after a good walk
  function automatic void ref_translate(input logic [VADDR_W-1:0] va, input access_e acc,
      output logic [PADDR_W-1:0] pa, output logic fault, output int reads,
      output logic fill, output logic [PPN_W-1:0] f_ppn, output logic [PTE_FLAGS_W-1:0] f_fl);
    logic [PTE_W-1:0] pte1;
    logic [PTE_W-1:0] pte0;
    pa    = '0;
    fault = 1'b0;
    reads = 0;
    fill  = 1'b0;
    f_ppn = '0;
    f_fl  = '0;
    if (!satp[SATP_MODE_BIT] || priv_mode == PRIV_M) begin
      pa = {2'b00, va};                                   // Bare
      return;
    end
    for (int i = 0; i < TLB_N; i++) begin
      if (m_valid[i] && m_vpn[i] == va[31:12]) begin
        pa    = {m_ppn[i], va[11:0]};
        fault = !perm_ok(m_flags[i], acc, priv_mode, mstatus_sum, mstatus_mxr);
        return;
      end
    end
    pte1  = pt_read({satp[PPN_W-1:0], va[31:22], 2'b00});
    reads = 1;
    if (!pte1[PTE_V] || (pte1[PTE_W_BIT] && !pte1[PTE_R]) || pte1[PTE_R] || pte1[PTE_X]) begin
      fault = 1'b1;                                       // Bad or superpage leaf
      return;
    end
    pte0  = pt_read({pte1[31:10], va[21:12], 2'b00});
    reads = 2;
    fault = !perm_ok(pte0[7:0], acc, priv_mode, mstatus_sum, mstatus_mxr);
    pa    = {pte0[31:10], va[11:0]};
    fill  = !fault;
    f_ppn = pte0[31:10];
    f_fl  = pte0[7:0];
  endfunction

  // ==========================================================
  // Stimulus helpers
  // ==========================================================

  task automatic write_mem(input logic [PADDR_W-1:0] a, input logic [PTE_W-1:0] d);
    pt[a] = d;
    mem_i.write_pte(a, d);
  endtask

  // Leaf at level 0 with its table made on first use
  task automatic map_page(input logic [VADDR_W-1:0] va, input logic [PPN_W-1:0] ppn,
                          input logic [PTE_FLAGS_W-1:0] fl);
    logic [PADDR_W-1:0] a1;
    a1 = {ROOT_PPN, va[31:22], 2'b00};
    if (!pt.exists(a1)) begin
      write_mem(a1, {22'h200 + 22'(va[31:22]), 2'b00, 8'h01});
    end
    write_mem({pt[a1][31:10], va[21:12], 2'b00}, {ppn, 2'b00, fl});
  endtask

  task automatic set_csr(input logic [VADDR_W-1:0] s, input priv_mode_e pm,
                         input logic sum, input logic mxr);
    @(posedge clk);
    satp        <= s;
    priv_mode   <= pm;
    mstatus_sum <= sum;
    mstatus_mxr <= mxr;
    @(posedge clk);  // New CSR values settled for the reference model
  endtask

  task automatic flush(input logic all, input logic [VADDR_W-1:0] va);
    @(posedge clk);
    tlb_flush_all   <= all;
    tlb_flush_vaddr <= !all;
    tlb_flush_addr  <= va;
    @(posedge clk);
    tlb_flush_all   <= 1'b0;
    tlb_flush_vaddr <= 1'b0;
    for (int i = 0; i < TLB_N; i++) begin
      if (all || m_vpn[i] == va[31:12]) m_valid[i] = 1'b0;
    end
  endtask

  task automatic do_req(input logic [VADDR_W-1:0] va, input access_e acc);
    logic [PADDR_W-1:0]     e_pa;
    logic                   e_fault;
    int                     e_reads;
    logic                   fill;
    logic [PPN_W-1:0]       f_ppn;
    logic [PTE_FLAGS_W-1:0] f_fl;
    int                     lat;
    ref_translate(va, acc, e_pa, e_fault, e_reads, fill, f_ppn, f_fl);
    if (fill) begin                                       // Round-robin fill
      m_valid[m_victim] = 1'b1;
      m_vpn[m_victim]   = va[31:12];
      m_ppn[m_victim]   = f_ppn;
      m_flags[m_victim] = f_fl;
      m_victim          = (m_victim + 1) % TLB_N;
    end
    exp_paddr_q.push_back(e_pa);
    exp_fault_q.push_back(e_fault);
    exp_reads_q.push_back(e_reads);
    start_reads_q.push_back(mem_i.read_count);
    @(posedge clk);
    req_valid  <= 1'b1;
    req_vaddr  <= va;
    req_access <= acc;
    lat = 0;
    do begin
      @(posedge clk);
      req_valid <= 1'b0;
      lat++;
      #1;
    end while (!req_done);
    if (e_reads == 0 && lat != 1) begin
      $display("Request to %h finished after %0d cycles instead of one", va, lat);
      err_other++;
    end
  endtask

  // ==========================================================
  // Compare tasks and checker
  // ==========================================================

  task automatic check_paddr(input logic [PADDR_W-1:0] got, input logic [PADDR_W-1:0] exp);
    if (got !== exp) begin
      $display("Error: req_paddr got %h expected %h", got, exp);
      err_value++;
    end
  endtask

  task automatic check_fault(input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error: req_page_fault got %h expected %h", got, exp);
      err_value++;
    end
  endtask

  task automatic check_reads(input int got, input int exp);
    if (got != exp) begin
      $display("Error: mem_req_valid reads got %h expected %h", got, exp);
      err_value++;
    end
  endtask

  always @(negedge clk) begin : compare_proc
    logic exp_f;
    if (reset_n && req_done) begin
      if (exp_fault_q.size() == 0) begin
        $display("req_done pulsed with no request outstanding");
        err_other++;
      end else begin
        exp_f = exp_fault_q.pop_front();
        check_fault(req_page_fault, exp_f);
        if (!exp_f) check_paddr(req_paddr, exp_paddr_q[0]);  // Address only on success
        void'(exp_paddr_q.pop_front());
        check_reads(mem_i.read_count - start_reads_q.pop_front(), exp_reads_q.pop_front());
      end
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles without finishing", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  // ==========================================================
  // Test sequence
  // ==========================================================

  initial begin
    logic [PTE_FLAGS_W-1:0] fl;
    logic [VADDR_W-1:0]     va;
    int                     r;
    err_value = 0;
    err_other = 0;
    cycle_cnt = 0;
    m_victim  = 0;
    for (int i = 0; i < TLB_N; i++) m_valid[i] = 1'b0;
    reset_n = 1'b0;
    req_valid = 1'b0;
    req_vaddr = '0;
    req_access = ACC_LOAD;
    satp = '0;
    priv_mode = PRIV_S;
    mstatus_sum = 1'b0;
    mstatus_mxr = 1'b0;
    tlb_flush_all = 1'b0;
    tlb_flush_vaddr = 1'b0;
    tlb_flush_addr = '0;
    repeat (4) @(posedge clk);
    reset_n <= 1'b1;

    // Bare mode then machine mode with Sv32 on
    do_req(32'hdead_beef, ACC_LOAD);
    do_req(32'h0000_1ffc, ACC_STORE);
    set_csr({1'b1, 9'h0, ROOT_PPN}, PRIV_M, 1'b0, 1'b0);
    do_req(32'h8765_4321, ACC_FETCH);
    do_req(32'hffff_f000, ACC_LOAD);

    // Walk then hit
    set_csr({1'b1, 9'h0, ROOT_PPN}, PRIV_S, 1'b0, 1'b0);
    map_page(32'h0040_1000, 22'h3_0001, 8'hc7);
    do_req(32'h0040_1234, ACC_LOAD);
    do_req(32'h0040_1abc, ACC_STORE);

    // Random permissions on fresh pages with a walk then a hit
    for (int i = 0; i < N_RAND; i++) begin
      va = 32'h1000_0000 + (i << 12);
      fl = 8'($random(seed));
      fl[PTE_V] = ($random(seed) & 7) != 0;               // Mostly valid
      map_page(va, 22'($random(seed)), fl);
      for (int k = 0; k < 2; k++) begin
        set_csr({1'b1, 9'h0, ROOT_PPN}, ($random(seed) & 1) ? PRIV_U : PRIV_S,
                1'($random(seed)), 1'($random(seed)));
        r = {$random(seed)} % 3;
        do_req(va | 32'(k * 12'h44), (r == 0) ? ACC_LOAD : (r == 1) ? ACC_STORE : ACC_FETCH);
      end
    end

    // Structural faults
    set_csr({1'b1, 9'h0, ROOT_PPN}, PRIV_S, 1'b1, 1'b0);
    map_page(32'h2040_0000, 22'h11, 8'h00);               // Invalid
    map_page(32'h2080_0000, 22'h12, 8'h05);               // W without R
    map_page(32'h20c0_0000, 22'h13, 8'h01);               // Pointer at level 0
    write_mem({ROOT_PPN, 10'h084, 2'b00}, {22'h14, 2'b00, 8'hcb});  // Superpage leaf
    do_req(32'h2040_0010, ACC_LOAD);
    do_req(32'h2080_0020, ACC_LOAD);
    do_req(32'h20c0_0030, ACC_LOAD);
    do_req(32'h2100_0040, ACC_LOAD);

    // Flush by address and flush all
    map_page(32'h3000_0000, 22'h21, 8'hcf);
    map_page(32'h3000_1000, 22'h22, 8'hcf);
    do_req(32'h3000_0100, ACC_LOAD);
    do_req(32'h3000_1100, ACC_LOAD);
    flush(1'b0, 32'h3000_0000);
    do_req(32'h3000_0200, ACC_STORE);
    do_req(32'h3000_1200, ACC_STORE);
    flush(1'b1, '0);
    do_req(32'h3000_0300, ACC_FETCH);
    do_req(32'h3000_1300, ACC_FETCH);

    // Round-robin eviction of the oldest page
    flush(1'b1, '0);
    for (int i = 0; i <= TLB_N; i++) begin
      map_page(32'h4000_0000 + (i << 12), 22'h30 + 22'(i), 8'hcf);
      do_req(32'h4000_0008 + (i << 12), ACC_LOAD);
    end
    do_req(32'h4000_0010, ACC_LOAD);

    repeat (3) @(posedge clk);
    if (exp_fault_q.size() != 0) begin
      $display("%0d expected results were never delivered", exp_fault_q.size());
      err_other++;
    end
    $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
    if (err_value == 0 && err_other == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== tb_page_table_mem.sv ====
`timescale 1ns/1ps

module tb_page_table_mem import mmu_pkg::*; (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               mem_req_valid,
  input  logic [PADDR_W-1:0] mem_req_addr,
  output logic               mem_req_ready,
  output logic               mem_resp_valid,
  output logic [PTE_W-1:0]   mem_resp_data
);

  // Sparse PTE storage, keyed by byte address
  logic [PTE_W-1:0] mem [logic [PADDR_W-1:0]];

  integer             seed = 61;
  int                 read_count;   // Accepted reads since reset
  int                 ready_wait;   // Cycles before ready rises
  int                 resp_wait;    // Cycles before data returns
  logic               pending;
  logic [PADDR_W-1:0] addr_q;

  task automatic write_pte(input logic [PADDR_W-1:0] addr, input logic [PTE_W-1:0] data);
    mem[addr] = data;
  endtask

  // ==========================================================
  // Read port with random ready and response delays
  // ==========================================================

  always @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      mem_req_ready  <= 1'b0;
      mem_resp_valid <= 1'b0;
      mem_resp_data  <= '0;
      read_count = 0;
      ready_wait = 0;
      resp_wait  = 0;
      pending    = 1'b0;
    end else begin
      mem_resp_valid <= 1'b0;                  // Single cycle pulse
      if (mem_req_valid && mem_req_ready) begin
        mem_req_ready <= 1'b0;                 // Accepted
        pending    = 1'b1;
        addr_q     = mem_req_addr;
        resp_wait  = $random(seed) & 3;
        ready_wait = $random(seed) & 3;        // Delay for the next request
        read_count++;
      end else if (pending) begin
        if (resp_wait == 0) begin
          mem_resp_valid <= 1'b1;
          mem_resp_data  <= mem.exists(addr_q) ? mem[addr_q] : '0;  // Unmapped reads invalid
          pending = 1'b0;
        end else begin
          resp_wait--;
        end
      end else if (mem_req_valid && !mem_req_ready) begin
        if (ready_wait == 0) begin
          mem_req_ready <= 1'b1;
        end else begin
          ready_wait--;
        end
      end
    end
  end

endmodule

// ==== sv32_mmu.sv ====
`timescale 1ns/1ps

module sv32_mmu import mmu_pkg::*; #(
  parameter int TLB_ENTRIES = 4
) (
  input  logic               clk,
  input  logic               reset_n,
  // Translation request
  input  logic               req_valid,
  input  logic [VADDR_W-1:0] req_vaddr,
  input  access_e            req_access,
  output logic               req_done,
  output logic [PADDR_W-1:0] req_paddr,
  output logic               req_page_fault,
  // CSRs
  input  logic [VADDR_W-1:0] satp,
  input  priv_mode_e         priv_mode,
  input  logic               mstatus_sum,
  input  logic               mstatus_mxr,
  // TLB maintenance
  input  logic               tlb_flush_all,
  input  logic               tlb_flush_vaddr,
  input  logic [VADDR_W-1:0] tlb_flush_addr,
  // Page table memory
  output logic               mem_req_valid,
  output logic [PADDR_W-1:0] mem_req_addr,
  input  logic               mem_req_ready,
  input  logic               mem_resp_valid,
  input  logic [PTE_W-1:0]   mem_resp_data
);

  logic                   xlate_en;       // Sv32 active for this privilege
  logic [VADDR_W-1:0]     vaddr_q;        // Request address during a walk

  logic                   tlb_hit;
  logic [PPN_W-1:0]       hit_ppn;
  logic [PTE_FLAGS_W-1:0] hit_flags;
  logic                   hit_allowed;

  logic                   bare_req;
  logic                   hit_req;
  logic                   walk_start;

  logic                   walk_done;
  logic                   walk_fault;
  logic [PPN_W-1:0]       walk_ppn;
  logic [PTE_FLAGS_W-1:0] walk_flags;
  logic                   fill_valid;

  // ==========================================================
  // Request decode
  // ==========================================================

  assign xlate_en   = satp[SATP_MODE_BIT] && (priv_mode != PRIV_M);
  assign bare_req   = req_valid && !xlate_en;
  assign hit_req    = req_valid && xlate_en && tlb_hit;
  assign walk_start = req_valid && xlate_en && !tlb_hit;  // Miss
  assign fill_valid = walk_done && !walk_fault;

  sv32_tlb #(
    .TLB_ENTRIES (TLB_ENTRIES)
  ) tlb_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .lookup_vpn  (req_vaddr[VADDR_W-1:PAGE_OFFSET_W]),
    .hit         (tlb_hit),
    .hit_ppn     (hit_ppn),
    .hit_flags   (hit_flags),
    .fill_valid  (fill_valid),
    .fill_vpn    (vaddr_q[VADDR_W-1:PAGE_OFFSET_W]),
    .fill_ppn    (walk_ppn),
    .fill_flags  (walk_flags),
    .flush_all   (tlb_flush_all),
    .flush_vaddr (tlb_flush_vaddr),
    .flush_vpn   (tlb_flush_addr[VADDR_W-1:PAGE_OFFSET_W])
  );

  // Permissions for TLB hits, the walker checks its own leaves
  pte_perm_check hit_check_i (
    .pte_flags   (hit_flags),
    .access      (req_access),
    .priv_mode   (priv_mode),
    .mstatus_sum (mstatus_sum),
    .mstatus_mxr (mstatus_mxr),
    .allowed     (hit_allowed)
  );

  sv32_ptw ptw_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .walk_start     (walk_start),
    .walk_vaddr     (req_vaddr),
    .walk_access    (req_access),
    .satp           (satp),
    .priv_mode      (priv_mode),
    .mstatus_sum    (mstatus_sum),
    .mstatus_mxr    (mstatus_mxr),
    .mem_req_valid  (mem_req_valid),
    .mem_req_addr   (mem_req_addr),
    .mem_req_ready  (mem_req_ready),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_data  (mem_resp_data),
    .walk_done      (walk_done),
    .walk_fault     (walk_fault),
    .walk_ppn       (walk_ppn),
    .walk_flags     (walk_flags)
  );

  // ==========================================================
  // Result registers
  // ==========================================================

  // Bare and hit answer next cycle, walks one cycle after walk_done
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      req_done       <= 1'b0;
      req_page_fault <= 1'b0;
    end else begin
      req_done       <= bare_req || hit_req || walk_done;
      req_page_fault <= (hit_req && !hit_allowed) || (walk_done && walk_fault);
    end
  end

  // Physical address holds between requests
  always_ff @(posedge clk) begin
    if (req_valid) begin
      vaddr_q <= req_vaddr;
    end
    if (bare_req) begin
      req_paddr <= {{(PADDR_W - VADDR_W){1'b0}}, req_vaddr};  // Identity map
    end else if (hit_req) begin
      req_paddr <= {hit_ppn, req_vaddr[PAGE_OFFSET_W-1:0]};
    end else if (fill_valid) begin
      req_paddr <= {walk_ppn, vaddr_q[PAGE_OFFSET_W-1:0]};
    end
  end

endmodule

// ==== sv32_ptw.sv ====
`timescale 1ns/1ps

module sv32_ptw import mmu_pkg::*; (
  input  logic                   clk,
  input  logic                   reset_n,
  // Walk request from the MMU
  input  logic                   walk_start,
  input  logic [VADDR_W-1:0]     walk_vaddr,
  input  access_e                walk_access,
  // CSR state, stable for the whole walk
  input  logic [VADDR_W-1:0]     satp,
  input  priv_mode_e             priv_mode,
  input  logic                   mstatus_sum,
  input  logic                   mstatus_mxr,
  // Memory read port
  output logic                   mem_req_valid,
  output logic [PADDR_W-1:0]     mem_req_addr,
  input  logic                   mem_req_ready,
  input  logic                   mem_resp_valid,
  input  logic [PTE_W-1:0]       mem_resp_data,
  // Walk result
  output logic                   walk_done,
  output logic                   walk_fault,
  output logic [PPN_W-1:0]       walk_ppn,
  output logic [PTE_FLAGS_W-1:0] walk_flags
);

  ptw_state_e            state_q;
  logic                  level_q;   // 1 while reading the root table
  logic [VPN_PART_W-1:0] vpn0_q;    // Index for the second level
  access_e               access_q;

  // Decode of the returned PTE
  logic [PPN_W-1:0]       resp_ppn;
  logic [PTE_FLAGS_W-1:0] resp_flags;
  logic                   resp_bad;   // Invalid or W without R
  logic                   resp_leaf;
  logic                   leaf_ok;    // Permission check result

  logic                   start_walk;
  logic                   resp_take;

  assign resp_ppn   = mem_resp_data[PTE_PPN_LSB +: PPN_W];
  assign resp_flags = mem_resp_data[PTE_FLAGS_W-1:0];
  assign resp_bad   = !resp_flags[PTE_V] || (resp_flags[PTE_W_BIT] && !resp_flags[PTE_R]);
  assign resp_leaf  = resp_flags[PTE_R] || resp_flags[PTE_X];

  assign start_walk = (state_q == PTW_IDLE) && walk_start;
  assign resp_take  = (state_q == PTW_WAIT) && mem_resp_valid;

  pte_perm_check leaf_check_i (
    .pte_flags   (resp_flags),
    .access      (access_q),
    .priv_mode   (priv_mode),
    .mstatus_sum (mstatus_sum),
    .mstatus_mxr (mstatus_mxr),
    .allowed     (leaf_ok)
  );

  // ==========================================================
  // Walk FSM
  // ==========================================================

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q       <= PTW_IDLE;
      level_q       <= 1'b0;
      mem_req_valid <= 1'b0;
    end else begin
      case (state_q)
        PTW_IDLE: begin
          if (walk_start) begin
            state_q <= PTW_REQ;
            level_q <= 1'b1;  // Sv32 starts at level 1
          end
        end
        PTW_REQ: begin
          if (!mem_req_valid) begin
            mem_req_valid <= 1'b1;  // Address already settled
          end else if (mem_req_ready) begin
            mem_req_valid <= 1'b0;  // Accepted this edge
            state_q       <= PTW_WAIT;
          end
        end
        PTW_WAIT: begin
          if (mem_resp_valid) begin
            if (resp_bad) begin
              state_q <= PTW_FAULT;
            end else if (resp_leaf) begin
              // No superpages, a level 1 leaf faults
              state_q <= (level_q || !leaf_ok) ? PTW_FAULT : PTW_DONE;
            end else if (level_q) begin
              level_q <= 1'b0;      // Descend
              state_q <= PTW_REQ;
            end else begin
              state_q <= PTW_FAULT; // Pointer at the last level
            end
          end
        end
        PTW_DONE, PTW_FAULT: state_q <= PTW_IDLE;  // One cycle result
        default:             state_q <= PTW_IDLE;
      endcase
    end
  end

  // ==========================================================
  // Address and PTE capture
  // ==========================================================

  always_ff @(posedge clk) begin
    if (start_walk) begin
      vpn0_q   <= walk_vaddr[PAGE_OFFSET_W +: VPN_PART_W];
      access_q <= walk_access;
      // Root table from satp.PPN, index VPN[1]
      mem_req_addr <= {satp[PPN_W-1:0], walk_vaddr[VADDR_W-1 -: VPN_PART_W],
                       {PTE_BYTES_SHIFT{1'b0}}};
    end
    if (resp_take) begin
      // Next table from PTE.PPN, index VPN[0]
      mem_req_addr <= {resp_ppn, vpn0_q, {PTE_BYTES_SHIFT{1'b0}}};
      walk_ppn     <= resp_ppn;
      walk_flags   <= resp_flags;
    end
  end

  assign walk_done  = (state_q == PTW_DONE) || (state_q == PTW_FAULT);
  assign walk_fault = (state_q == PTW_FAULT);

endmodule

// ==== sv32_tlb.sv ====
`timescale 1ns/1ps

module sv32_tlb import mmu_pkg::*; #(
  parameter int TLB_ENTRIES = 4  // Power of two
) (
  input  logic                   clk,
  input  logic                   reset_n,
  // Lookup port
  input  logic [VPN_W-1:0]       lookup_vpn,
  output logic                   hit,
  output logic [PPN_W-1:0]       hit_ppn,
  output logic [PTE_FLAGS_W-1:0] hit_flags,
  // Fill from a successful walk
  input  logic                   fill_valid,
  input  logic [VPN_W-1:0]       fill_vpn,
  input  logic [PPN_W-1:0]       fill_ppn,
  input  logic [PTE_FLAGS_W-1:0] fill_flags,
  // Flush requests
  input  logic                   flush_all,
  input  logic                   flush_vaddr,
  input  logic [VPN_W-1:0]       flush_vpn
);

  localparam int IDX_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

  // ==========================================================
  // Entry storage
  // ==========================================================

  logic [TLB_ENTRIES-1:0] valid_q;
  logic [VPN_W-1:0]       vpn_q   [TLB_ENTRIES];
  logic [PPN_W-1:0]       ppn_q   [TLB_ENTRIES];
  logic [PTE_FLAGS_W-1:0] flags_q [TLB_ENTRIES];

  logic [IDX_W-1:0]       victim_q;     // Round-robin fill pointer

  logic [TLB_ENTRIES-1:0] lookup_match;
  logic [TLB_ENTRIES-1:0] flush_match;  // Tag compare only

  // ==========================================================
  // Parallel compare
  // ==========================================================

  // At most one entry can match since fills only follow misses
  always_comb begin
    hit       = 1'b0;
    hit_ppn   = '0;
    hit_flags = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      lookup_match[i] = valid_q[i] && (vpn_q[i] == lookup_vpn);
      flush_match[i]  = (vpn_q[i] == flush_vpn);
      if (lookup_match[i]) begin
        hit       = 1'b1;
        hit_ppn   = ppn_q[i];
        hit_flags = flags_q[i];
      end
    end
  end

  // ==========================================================
  // Valid bits and victim pointer
  // ==========================================================

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      valid_q  <= '0;
      victim_q <= '0;
    end else begin
      if (flush_all) begin
        valid_q <= '0;
      end else if (flush_vaddr) begin
        valid_q <= valid_q & ~flush_match;  // Drop every matching page
      end
      if (fill_valid) begin
        valid_q[victim_q] <= 1'b1;
        // Wrap explicitly
        victim_q <= (victim_q == IDX_W'(TLB_ENTRIES - 1)) ? '0 : victim_q + 1'b1;
      end
    end
  end

  // Tag and data written at the victim slot
  always_ff @(posedge clk) begin
    if (fill_valid) begin
      vpn_q[victim_q]   <= fill_vpn;
      ppn_q[victim_q]   <= fill_ppn;
      flags_q[victim_q] <= fill_flags;
    end
  end

endmodule

// ==== pte_perm_check.sv ====
`timescale 1ns/1ps

module pte_perm_check import mmu_pkg::*; (
  input  logic [PTE_FLAGS_W-1:0] pte_flags,
  input  access_e                access,
  input  priv_mode_e             priv_mode,
  input  logic                   mstatus_sum,
  input  logic                   mstatus_mxr,
  output logic                   allowed
);

  // Flag aliases
  logic flag_v;
  logic flag_r;
  logic flag_w;
  logic flag_x;
  logic flag_u;

  assign flag_v = pte_flags[PTE_V];
  assign flag_r = pte_flags[PTE_R];
  assign flag_w = pte_flags[PTE_W_BIT];
  assign flag_x = pte_flags[PTE_X];
  assign flag_u = pte_flags[PTE_U];

  // Rules in priority order, first failure wins
  always_comb begin
    allowed = 1'b1;
    if (!flag_v) begin
      allowed = 1'b0;                       // Invalid entry
    end else if (!flag_r && !flag_x) begin
      allowed = 1'b0;                       // Pointer, not a leaf
    end else if (flag_w && !flag_r) begin
      allowed = 1'b0;                       // Reserved encoding
    end else if (priv_mode == PRIV_U && !flag_u) begin
      allowed = 1'b0;                       // User touching supervisor page
    end else if (priv_mode == PRIV_S && flag_u &&
                 (!mstatus_sum || access == ACC_FETCH)) begin
      // Supervisor on a user page
      // SUM never opens fetch
      allowed = 1'b0;
    end else begin
      // Access type rights
      case (access)
        ACC_FETCH: allowed = flag_x;
        ACC_STORE: allowed = flag_w;
        default:   allowed = flag_r || (flag_x && mstatus_mxr);  // Load
      endcase
    end
  end

endmodule

// ==== mmu_pkg.sv ====
package mmu_pkg;

  // ==========================================================
  // Sv32 address geometry
  // ==========================================================

  localparam int VADDR_W       = 32;  // Virtual address
  localparam int PADDR_W       = 34;  // Physical address
  localparam int PAGE_OFFSET_W = 12;  // 4 KiB pages
  localparam int VPN_W         = VADDR_W - PAGE_OFFSET_W;  // VPN[1] and VPN[0]
  localparam int VPN_PART_W    = 10;  // One level of the walk
  localparam int PPN_W         = PADDR_W - PAGE_OFFSET_W;  // 22 bits

  // satp fields
  localparam int SATP_MODE_BIT = 31;  // 1 selects Sv32

  // ==========================================================
  // Page table entry layout
  // ==========================================================

  localparam int PTE_W           = 32;
  localparam int PTE_BYTES_SHIFT = 2;   // 4-byte entries
  localparam int PTE_PPN_LSB     = 10;  // PPN sits above RSW

  // Flag bit positions
  localparam int PTE_V     = 0;
  localparam int PTE_R     = 1;
  localparam int PTE_W_BIT = 2;  // Write permission
  localparam int PTE_X     = 3;
  localparam int PTE_U     = 4;
  localparam int PTE_G     = 5;
  localparam int PTE_A     = 6;
  localparam int PTE_D     = 7;

  localparam int PTE_FLAGS_W = PTE_D + 1;  // V through D

  // ==========================================================
  // Enumerations
  // ==========================================================

  // Privilege levels as the core encodes them
  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_mode_e;

  typedef enum logic [1:0] {
    ACC_LOAD,
    ACC_STORE,
    ACC_FETCH
  } access_e;

  // Walker FSM
  typedef enum logic [2:0] {
    PTW_IDLE,
    PTW_REQ,    // Address presented, waiting for accept
    PTW_WAIT,   // Accepted, waiting for PTE data
    PTW_DONE,
    PTW_FAULT
  } ptw_state_e;

endpackage
